/* hdl/radio_core_pkg.sv */
// shared types and address map; I/Q are signed 16-bit, and both slices decode the same window
package radio_core_pkg;

   // --------------------------------------------------
   // widths with a meaning
   // --------------------------------------------------
   typedef logic [31:0]        word_t;     // settings, gpio and misc words
   typedef logic [7:0]         set_addr_t; // settings and readback address
   typedef logic signed [15:0] iq_t;       // one I or Q component

   typedef struct packed {
      iq_t i;                              // upper 16 bits
      iq_t q;                              // lower 16 bits
   } sample_t;

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      word_t     data;
   } set_bus_t;

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
   } rb_req_t;

   typedef struct packed {
      logic        stb;
      logic [63:0] data;
   } rb_resp_t;

   typedef struct packed {
      word_t out;
      word_t ddr;                          // 1 = pin driven
   } gpio_ctrl_t;

   typedef struct packed {
      logic [2:0] misc;
      logic       pps_present;
      logic       holdover;
      logic       lock;
      logic [1:0] lmk_status;
   } clk_status_t;

   // --------------------------------------------------
   // address map
   // --------------------------------------------------
   localparam set_addr_t SR_DB_BASE        = 8'd160;
   localparam set_addr_t SR_DB_GPIO_OUT    = 8'd0;   // offsets from SR_DB_BASE
   localparam set_addr_t SR_DB_GPIO_DDR    = 8'd1;
   localparam set_addr_t SR_FP_GPIO_OUT    = 8'd2;
   localparam set_addr_t SR_FP_GPIO_DDR    = 8'd3;
   localparam set_addr_t SR_MISC_OUT       = 8'd4;
   localparam set_addr_t SR_LEDS           = 8'd5;

   localparam set_addr_t RB_DB_BASE        = 8'd16;
   localparam set_addr_t RB_MISC_IN        = 8'd0;   // offsets from RB_DB_BASE
   localparam set_addr_t RB_DB_GPIO_IN     = 8'd1;
   localparam set_addr_t RB_FP_GPIO_IN     = 8'd2;
   localparam set_addr_t RB_CLK_STATUS     = 8'd3;

   localparam set_addr_t SR_TX_FE_BASE     = 8'd208;
   localparam set_addr_t SR_RX_FE_BASE     = 8'd224;
   localparam set_addr_t SR_FE_CHAN_OFFSET = 8'd16;

   // top level defaults
   localparam int NUM_DBOARDS_DEF         = 2;
   localparam int NUM_CHANNELS_PER_DB_DEF = 2;
   localparam int FP_GPIO_WIDTH           = 12;

endpackage

/* hdl/pps_detect.sv */
// i_pps may be asynchronous; presence drops PPS_TIMEOUT cycles after the last synchronized edge
`timescale 1ns/100ps

module pps_detect #(
   parameter int PPS_TIMEOUT = 200_000_000
)(
   input  logic radio_clk,
   input  logic i_rst,
   input  logic i_pps,
   output logic o_pps_present
);

   localparam int CNT_W = $clog2(PPS_TIMEOUT + 1);

   logic [1:0]       pps_sync;  // two-flop synchronizer
   logic             pps_d;
   logic [CNT_W-1:0] timeout_cnt;

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         pps_sync    <= '0;
         pps_d       <= 1'b0;
         timeout_cnt <= '0;
      end else begin
         pps_sync <= {pps_sync[0], i_pps};
         pps_d    <= pps_sync[1];
         if (pps_sync[1] && !pps_d) begin
            timeout_cnt <= CNT_W'(PPS_TIMEOUT);  // rising edge reloads
         end else if (timeout_cnt != '0) begin
            timeout_cnt <= timeout_cnt - 1'b1;
         end
      end
   end

   assign o_pps_present = (timeout_cnt != '0);

endmodule

/* hdl/symbol_modulator.sv */
// 16 QPSK symbols per 32-bit word, no enable input; AMPLITUDE must fit in a signed 16-bit value
`timescale 1ns/100ps

module symbol_modulator import radio_core_pkg::*; #(
   parameter int NSYMB     = 8,
   parameter int AMPLITUDE = 8192
)(
   input  logic    radio_clk,
   input  logic    i_rst,
   input  word_t   i_tx_bits,
   output sample_t o_tx,
   output logic    o_tx_valid
);

   localparam int  HOLD_W  = (NSYMB > 1) ? $clog2(NSYMB) : 1;
   localparam iq_t AMP_POS = iq_t'(AMPLITUDE);
   localparam iq_t AMP_NEG = iq_t'(-AMPLITUDE);

   typedef enum logic [1:0] {
      IDLE,
      LATCH,
      SEND
   } state_t;

   state_t            state;
   logic [1:0]        idle_cnt;
   logic [3:0]        sym_idx;   // symbol within the frame
   logic [HOLD_W-1:0] hold_cnt;  // cycles spent on this symbol
   word_t             bits_q;
   logic [1:0]        sym_bits;
   logic              last_hold;
   logic              frame_end;

   assign last_hold = (hold_cnt == HOLD_W'(NSYMB - 1));
   assign frame_end = (state == SEND) && last_hold && (sym_idx == 4'd15);

   // --------------------------------------------------
   // FSM
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         state    <= IDLE;
         idle_cnt <= '0;
         sym_idx  <= '0;
         hold_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               idle_cnt <= idle_cnt + 1'b1;
               if (idle_cnt == 2'd3) begin
                  state <= LATCH;
               end
            end
            LATCH: begin
               sym_idx  <= '0;
               hold_cnt <= '0;
               state    <= SEND;
            end
            SEND: begin
               if (last_hold) begin
                  hold_cnt <= '0;
                  sym_idx  <= sym_idx + 1'b1;  // wraps into the next frame
               end else begin
                  hold_cnt <= hold_cnt + 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // word captured at every frame start, back-to-back frames skip LATCH
   always_ff @(posedge radio_clk) begin
      if (state == LATCH || frame_end) begin
         bits_q <= i_tx_bits;
      end
   end

   // --------------------------------------------------
   // symbol mapping
   // --------------------------------------------------
   assign sym_bits   = bits_q[{sym_idx, 1'b0} +: 2];
   assign o_tx.i     = sym_bits[0] ? AMP_NEG : AMP_POS;  // bit 2k
   assign o_tx.q     = sym_bits[1] ? AMP_NEG : AMP_POS;  // bit 2k+1
   assign o_tx_valid = (state == SEND);

endmodule

/* hdl/db_control.sv */
// decodes only SR_DB_BASE+0..5 and RB_DB_BASE+0..3; other addresses write nothing and read 0
`timescale 1ns/100ps

module db_control import radio_core_pkg::*; (
   input  logic        radio_clk,
   input  logic        i_rst,
   input  set_bus_t    i_set,
   input  rb_req_t     i_rb_req,
   input  word_t       i_misc_in,
   input  word_t       i_db_gpio_in,
   input  word_t       i_fp_gpio_in,
   input  clk_status_t i_clock_status,
   output rb_resp_t    o_rb_resp,
   output gpio_ctrl_t  o_db_gpio,
   output gpio_ctrl_t  o_fp_gpio,
   output word_t       o_misc_out,
   output logic [2:0]  o_leds
);

   word_t misc_in_q;
   word_t rb_sel;

   // --------------------------------------------------
   // settings registers
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_db_gpio  <= '0;
         o_fp_gpio  <= '0;
         o_misc_out <= '0;
         o_leds     <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            SR_DB_BASE + SR_DB_GPIO_OUT: o_db_gpio.out <= i_set.data;
            SR_DB_BASE + SR_DB_GPIO_DDR: o_db_gpio.ddr <= i_set.data;
            SR_DB_BASE + SR_FP_GPIO_OUT: o_fp_gpio.out <= i_set.data;
            SR_DB_BASE + SR_FP_GPIO_DDR: o_fp_gpio.ddr <= i_set.data;
            SR_DB_BASE + SR_MISC_OUT:    o_misc_out    <= i_set.data;
            SR_DB_BASE + SR_LEDS:        o_leds        <= i_set.data[2:0];  // {rx, txrx_tx, txrx_rx}
            default: ;                   // not ours
         endcase
      end
   end

   // misc input pipeline stage
   always_ff @(posedge radio_clk) begin
      misc_in_q <= i_misc_in;
   end

   // --------------------------------------------------
   // readback
   // --------------------------------------------------
   always_comb begin
      rb_sel = '0;
      case (i_rb_req.addr)
         RB_DB_BASE + RB_MISC_IN:    rb_sel = misc_in_q;
         RB_DB_BASE + RB_DB_GPIO_IN: rb_sel = i_db_gpio_in;
         RB_DB_BASE + RB_FP_GPIO_IN: rb_sel = i_fp_gpio_in;
         RB_DB_BASE + RB_CLK_STATUS: rb_sel = {24'd0, i_clock_status};
         default:                    rb_sel = '0;
      endcase
   end

   // response one cycle after the request, data sampled at request time
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_rb_resp <= '0;
      end else begin
         o_rb_resp.stb  <= i_rb_req.stb;
         o_rb_resp.data <= {32'd0, rb_sel};
      end
   end

endmodule

/* hdl/fe_control.sv */
// one register per channel; TX channel 1 address equals RX channel 0 address, a write hits both
`timescale 1ns/100ps

module fe_control import radio_core_pkg::*; #(
   parameter int NUM_CHANNELS = NUM_CHANNELS_PER_DB_DEF
)(
   input  logic     radio_clk,
   input  logic     i_rst,
   input  set_bus_t i_set,
   input  sample_t  i_rx [NUM_CHANNELS],
   input  sample_t  i_tx,
   input  logic     i_tx_valid,
   output sample_t  o_rx [NUM_CHANNELS],
   output sample_t  o_tx [NUM_CHANNELS],
   output logic     o_tx_valid
);

   // signed add clamped to the 16-bit range
   function automatic iq_t sat_add(input iq_t a, input iq_t b);
      logic signed [16:0] sum;
      sum = a + b;
      if (sum[16] != sum[15]) begin
         return sum[16] ? 16'sh8000 : 16'sh7fff;
      end
      return sum[15:0];
   endfunction

   for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
      localparam set_addr_t RX_ADDR = set_addr_t'(SR_RX_FE_BASE + c*SR_FE_CHAN_OFFSET);
      localparam set_addr_t TX_ADDR = set_addr_t'(SR_TX_FE_BASE + c*SR_FE_CHAN_OFFSET);

      sample_t rx_offset;  // I offset high, Q offset low
      logic    tx_swap;

      // --------------------------------------------------
      // channel settings
      // --------------------------------------------------
      always_ff @(posedge radio_clk) begin
         if (i_rst) begin
            rx_offset <= '0;
            tx_swap   <= 1'b0;
         end else if (i_set.stb) begin
            if (i_set.addr == RX_ADDR) begin
               rx_offset <= i_set.data;
            end
            if (i_set.addr == TX_ADDR) begin
               tx_swap <= i_set.data[0];  // upper bits ignored
            end
         end
      end

      // datapath, one register stage each way
      always_ff @(posedge radio_clk) begin
         o_rx[c].i <= sat_add(i_rx[c].i, rx_offset.i);
         o_rx[c].q <= sat_add(i_rx[c].q, rx_offset.q);
         if (tx_swap) begin
            o_tx[c].i <= i_tx.q;
            o_tx[c].q <= i_tx.i;
         end else begin
            o_tx[c] <= i_tx;
         end
      end
   end

   // valid tracks the tx register stage
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_tx_valid <= 1'b0;
      end else begin
         o_tx_valid <= i_tx_valid;
      end
   end

endmodule

/* hdl/radio_core.sv */
// radio clock domain only; settings and readback come in as ports, TX pins carry channel 0 only
`timescale 1ns/100ps

module radio_core import radio_core_pkg::*; #(
   parameter int NUM_DBOARDS         = NUM_DBOARDS_DEF,
   parameter int NUM_CHANNELS_PER_DB = NUM_CHANNELS_PER_DB_DEF,
   parameter int NSYMB               = 8,
   parameter int AMPLITUDE           = 8192,
   parameter int PPS_TIMEOUT         = 200_000_000  // about 1 s at 200 MHz
)(
   input  logic        radio_clk,
   input  logic        i_rst,
   input  set_bus_t    i_set        [NUM_DBOARDS],
   input  rb_req_t     i_rb_req     [NUM_DBOARDS],
   input  sample_t     i_rx         [NUM_DBOARDS],
   input  word_t       i_db_gpio_in [NUM_DBOARDS],
   input  word_t       i_misc_in    [NUM_DBOARDS],
   input  word_t       i_fp_gpio_in,
   input  logic        i_pps,
   input  clk_status_t i_clock_status,
   output rb_resp_t    o_rb_resp    [NUM_DBOARDS],
   output gpio_ctrl_t  o_db_gpio    [NUM_DBOARDS],
   output word_t       o_misc_out   [NUM_DBOARDS],
   output logic [2:0]  o_radio_led  [NUM_DBOARDS],
   output gpio_ctrl_t  o_fp_gpio,
   output sample_t     o_tx         [NUM_DBOARDS],
   output logic        o_tx_valid,
   output sample_t     o_rx         [NUM_DBOARDS*NUM_CHANNELS_PER_DB]
);

   localparam word_t FP_GPIO_MASK = word_t'((64'd1 << FP_GPIO_WIDTH) - 1);

   logic        pps_present;
   clk_status_t clk_status;
   sample_t     mod_tx;
   logic        mod_valid;
   gpio_ctrl_t  db_gpio_r  [NUM_DBOARDS];
   gpio_ctrl_t  fp_gpio_r  [NUM_DBOARDS];
   word_t       misc_out_r [NUM_DBOARDS];
   logic        tx_valid_r [NUM_DBOARDS];  // identical per slice, slice 0 drives the pin

   pps_detect #(.PPS_TIMEOUT(PPS_TIMEOUT)) pps_detect_i (
      .radio_clk     (radio_clk),
      .i_rst         (i_rst),
      .i_pps         (i_pps),
      .o_pps_present (pps_present)
   );

   always_comb begin
      clk_status             = i_clock_status;
      clk_status.pps_present = pps_present;  // external pps bit is ignored
   end

   // modulator always owns the TX path, fed by slice 0 fp gpio word
   symbol_modulator #(.NSYMB(NSYMB), .AMPLITUDE(AMPLITUDE)) symbol_modulator_i (
      .radio_clk  (radio_clk),
      .i_rst      (i_rst),
      .i_tx_bits  (fp_gpio_r[0].out),
      .o_tx       (mod_tx),
      .o_tx_valid (mod_valid)
   );

   // --------------------------------------------------
   // daughterboard slices
   // --------------------------------------------------
   for (genvar d = 0; d < NUM_DBOARDS; d++) begin : g_slice
      sample_t rx_in  [NUM_CHANNELS_PER_DB];
      sample_t rx_out [NUM_CHANNELS_PER_DB];
      sample_t tx_out [NUM_CHANNELS_PER_DB];

      db_control db_control_i (
         .radio_clk      (radio_clk),
         .i_rst          (i_rst),
         .i_set          (i_set[d]),
         .i_rb_req       (i_rb_req[d]),
         .i_misc_in      (i_misc_in[d]),
         .i_db_gpio_in   (i_db_gpio_in[d]),
         .i_fp_gpio_in   (i_fp_gpio_in),
         .i_clock_status (clk_status),
         .o_rb_resp      (o_rb_resp[d]),
         .o_db_gpio      (db_gpio_r[d]),
         .o_fp_gpio      (fp_gpio_r[d]),
         .o_misc_out     (misc_out_r[d]),
         .o_leds         (o_radio_led[d])
      );

      fe_control #(.NUM_CHANNELS(NUM_CHANNELS_PER_DB)) fe_control_i (
         .radio_clk  (radio_clk),
         .i_rst      (i_rst),
         .i_set      (i_set[d]),
         .i_rx       (rx_in),
         .i_tx       (mod_tx),
         .i_tx_valid (mod_valid),
         .o_rx       (rx_out),
         .o_tx       (tx_out),
         .o_tx_valid (tx_valid_r[d])
      );

      for (genvar c = 0; c < NUM_CHANNELS_PER_DB; c++) begin : g_chan
         assign rx_in[c] = i_rx[d];  // one adc stream feeds every channel
         assign o_rx[d*NUM_CHANNELS_PER_DB + c] = rx_out[c];
      end

      assign o_tx[d] = tx_out[0];
   end

   assign o_tx_valid = tx_valid_r[0];

   // pin output registers
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_fp_gpio <= '0;
         for (int d = 0; d < NUM_DBOARDS; d++) begin
            o_db_gpio[d]  <= '0;
            o_misc_out[d] <= '0;
         end
      end else begin
         o_fp_gpio.out <= fp_gpio_r[0].out & FP_GPIO_MASK;
         o_fp_gpio.ddr <= fp_gpio_r[0].ddr & FP_GPIO_MASK;
         for (int d = 0; d < NUM_DBOARDS; d++) begin
            o_db_gpio[d]  <= db_gpio_r[d];
            o_misc_out[d] <= misc_out_r[d];
         end
      end
   end

endmodule

/* test/radio_core_tb.sv */
// both slices driven, pps timeout shortened to 64 cycles, TX pins carry channel 0 of each slice only
`timescale 1ns/100ps

module radio_core_tb import radio_core_pkg::*; ();

   localparam int    NDB         = 2;
   localparam int    NCH         = 2;
   localparam int    NSYMB       = 8;
   localparam int    AMPLITUDE   = 8192;
   localparam int    PPS_TIMEOUT = 64;
   localparam int    HALF_PERIOD = 2;
   localparam int    FRAME_LEN   = 16 * NSYMB;
   localparam word_t FP_MASK     = {{(32 - FP_GPIO_WIDTH){1'b0}}, {FP_GPIO_WIDTH{1'b1}}};
   // reset, regs, rx, two tx runs, pps, isolation
   localparam int    TEST_CYCLES = 20 + 200 + 110 + 2 * (3 * FRAME_LEN + 20) + 5 * 55 + 90 + 150;
   localparam int    MARGIN      = 500;

   logic        radio_clk = 1'b0;
   logic        rst;
   set_bus_t    set_bus     [NDB];
   rb_req_t     rb_req      [NDB];
   sample_t     rx_in       [NDB];
   word_t       db_gpio_in  [NDB];
   word_t       misc_in     [NDB];
   word_t       fp_gpio_in;
   logic        pps;
   clk_status_t clock_status;
   rb_resp_t    rb_resp     [NDB];
   gpio_ctrl_t  db_gpio     [NDB];
   word_t       misc_out    [NDB];
   logic [2:0]  radio_led   [NDB];
   gpio_ctrl_t  fp_gpio;
   sample_t     tx_out      [NDB];
   logic        tx_valid;
   sample_t     rx_out      [NDB*NCH];

   word_t   shadow [NDB][6];  // db register model, indexed by offset
   sample_t rx_off [NDB][NCH];
   int      tx_count;         // index of the TX sample now on the pins
   int      checks = 0;
   int      errors = 0;
   int      test_errors;

   radio_core #(
      .NUM_DBOARDS(NDB), .NUM_CHANNELS_PER_DB(NCH), .NSYMB(NSYMB),
      .AMPLITUDE(AMPLITUDE), .PPS_TIMEOUT(PPS_TIMEOUT)
   ) radio_core_i (
      .radio_clk(radio_clk), .i_rst(rst), .i_set(set_bus), .i_rb_req(rb_req),
      .i_rx(rx_in), .i_db_gpio_in(db_gpio_in), .i_misc_in(misc_in),
      .i_fp_gpio_in(fp_gpio_in), .i_pps(pps), .i_clock_status(clock_status),
      .o_rb_resp(rb_resp), .o_db_gpio(db_gpio), .o_misc_out(misc_out),
      .o_radio_led(radio_led), .o_fp_gpio(fp_gpio), .o_tx(tx_out),
      .o_tx_valid(tx_valid), .o_rx(rx_out)
   );

   always #HALF_PERIOD radio_clk = ~radio_clk;

   always @(posedge radio_clk) begin
      if (rst) tx_count <= 0;
      else if (tx_valid) tx_count <= tx_count + 1;  // counts from first valid sample
   end

   // --------------------------------------------------
   // compare tasks and reference model
   // --------------------------------------------------
   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at time %0t: %s got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_sample(input string name, input sample_t got, input sample_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at time %0t: %s got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_rb(input string name, input rb_resp_t got, input rb_resp_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at time %0t: %s got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic end_test(input string name);
      if (errors == test_errors) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, errors - test_errors);
      test_errors = errors;
   endtask

   function automatic iq_t sat_sum(input iq_t a, input iq_t b);
      int s;
      s = int'(a) + int'(b);
      if (s > 32767) s = 32767;
      else if (s < -32768) s = -32768;
      return iq_t'(s);
   endfunction

   function automatic iq_t rand_iq();  // biased toward the rails
      case ($urandom % 4)
         0:       return 16'sh7fff - iq_t'($urandom % 64);
         1:       return 16'sh8000 + iq_t'($urandom % 64);
         default: return iq_t'($urandom);
      endcase
   endfunction

   // symbol k of a frame maps bits 2k (I) and 2k+1 (Q), set bit gives minus
   function automatic sample_t qpsk(input word_t w, input int n);
      sample_t s;
      int      k;
      k = (n / NSYMB) % 16;
      s.i = w[2*k] ? iq_t'(-AMPLITUDE) : iq_t'(AMPLITUDE);
      s.q = w[2*k+1] ? iq_t'(-AMPLITUDE) : iq_t'(AMPLITUDE);
      return s;
   endfunction

   function automatic word_t status_word(input clk_status_t s, input logic present);
      s.pps_present = present;
      return word_t'(s);
   endfunction

   function automatic set_addr_t unmapped_addr();
      set_addr_t a;
      do a = set_addr_t'($urandom % 256);
      while ((a >= SR_DB_BASE && a <= SR_DB_BASE + SR_LEDS) || a == SR_TX_FE_BASE ||
             a == SR_RX_FE_BASE || a == SR_RX_FE_BASE + SR_FE_CHAN_OFFSET);
      return a;
   endfunction

   // --------------------------------------------------
   // bus drivers, called on a falling edge
   // --------------------------------------------------
   task automatic write_reg(input int d, input set_addr_t addr, input word_t data);
      set_bus[d].stb  = 1'b1;
      set_bus[d].addr = addr;
      set_bus[d].data = data;
      @(negedge radio_clk);
      set_bus[d].stb = 1'b0;
   endtask

   task automatic write_db(input int d, input int off, input word_t data);
      write_reg(d, SR_DB_BASE + set_addr_t'(off), data);
      shadow[d][off] = data;
   endtask

   task automatic check_regs();
      for (int d = 0; d < NDB; d++) begin
         check_word($sformatf("o_db_gpio[%0d].out", d), db_gpio[d].out, shadow[d][0]);
         check_word($sformatf("o_db_gpio[%0d].ddr", d), db_gpio[d].ddr, shadow[d][1]);
         check_word($sformatf("o_misc_out[%0d]", d), misc_out[d], shadow[d][4]);
         check_word($sformatf("o_radio_led[%0d]", d), word_t'(radio_led[d]), shadow[d][5] & 7);
      end
      check_word("o_fp_gpio.out", fp_gpio.out, shadow[0][2] & FP_MASK);
      check_word("o_fp_gpio.ddr", fp_gpio.ddr, shadow[0][3] & FP_MASK);
   endtask

   task automatic read_check(input int d, input set_addr_t off, input word_t exp);
      rb_resp_t e;
      rb_req[d].stb  = 1'b1;
      rb_req[d].addr = RB_DB_BASE + off;
      @(negedge radio_clk);
      rb_req[d] = '0;
      e.stb  = 1'b1;
      e.data = {32'd0, exp};
      check_rb($sformatf("o_rb_resp[%0d] offset %0d", d, off), rb_resp[d], e);
      @(negedge radio_clk);
      check_rb($sformatf("o_rb_resp[%0d] idle", d), rb_resp[d], '0);  // one strobe only
   endtask

   task automatic run_rx(input int cycles);
      sample_t prev [NDB];
      sample_t exp;
      for (int n = 0; n <= cycles; n++) begin
         if (n > 0) begin
            for (int i = 0; i < NDB * NCH; i++) begin
               exp.i = sat_sum(prev[i/NCH].i, rx_off[i/NCH][i%NCH].i);
               exp.q = sat_sum(prev[i/NCH].q, rx_off[i/NCH][i%NCH].q);
               check_sample($sformatf("o_rx[%0d]", i), rx_out[i], exp);
            end
         end
         for (int d = 0; d < NDB; d++) begin
            prev[d].i = rand_iq();
            prev[d].q = rand_iq();
            rx_in[d]  = prev[d];
         end
         @(negedge radio_clk);
      end
   endtask

   task automatic wait_frame_start();
      while (!(tx_valid && tx_count % FRAME_LEN == 0)) @(negedge radio_clk);
   endtask

   task automatic run_tx_frames(input logic swap1);
      word_t   w;
      sample_t exp;
      w = $urandom;
      write_reg(0, SR_TX_FE_BASE, 32'd0);
      write_reg(1, SR_TX_FE_BASE, {31'd0, swap1});
      write_db(0, SR_FP_GPIO_OUT, w);
      wait_frame_start();     // this frame may hold the old word
      @(negedge radio_clk);
      wait_frame_start();
      for (int n = 0; n < FRAME_LEN; n++) begin
         exp = qpsk(w, tx_count);
         check_word("o_tx_valid", word_t'(tx_valid), 32'd1);
         check_sample("o_tx[0]", tx_out[0], exp);
         check_sample("o_tx[1]", tx_out[1], swap1 ? {exp.q, exp.i} : exp);
         @(negedge radio_clk);
      end
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      void'($urandom(33));
      rst = 1'b1;
      pps = 1'b0;
      fp_gpio_in   = '0;
      clock_status = '0;
      for (int d = 0; d < NDB; d++) begin
         set_bus[d] = '0;
         rb_req[d]  = '0;
         rx_in[d]   = '0;
         db_gpio_in[d] = '0;
         misc_in[d]    = '0;
         for (int o = 0; o < 6; o++) shadow[d][o] = '0;
         for (int c = 0; c < NCH; c++) rx_off[d][c] = '0;
      end
      test_errors = 0;
      repeat (8) @(posedge radio_clk);
      @(negedge radio_clk);
      rst = 1'b0;

      check_word("o_tx_valid", word_t'(tx_valid), 32'd0);
      for (int d = 0; d < NDB; d++) check_word("o_rb_resp.stb", word_t'(rb_resp[d].stb), 32'd0);
      check_regs();
      for (int d = 0; d < NDB; d++) begin
         for (int o = 0; o < 4; o++) read_check(d, set_addr_t'(o), 32'd0);
      end
      end_test("reset state");

      for (int pass = 0; pass < 3; pass++) begin
         for (int d = 0; d < NDB; d++) begin
            for (int o = 0; o < 6; o++) begin
               write_db(d, o, $urandom);
               @(negedge radio_clk);
               check_regs();        // pins one cycle after the write
            end
         end
      end
      fp_gpio_in   = $urandom;
      clock_status = 8'($urandom);  // pps bit here is ignored by the DUT
      for (int d = 0; d < NDB; d++) begin
         misc_in[d]    = $urandom;
         db_gpio_in[d] = $urandom;
      end
      @(negedge radio_clk);
      for (int d = 0; d < NDB; d++) begin
         read_check(d, RB_MISC_IN, misc_in[d]);
         read_check(d, RB_DB_GPIO_IN, db_gpio_in[d]);
         read_check(d, RB_FP_GPIO_IN, fp_gpio_in);
         read_check(d, RB_CLK_STATUS, status_word(clock_status, 1'b0));
         read_check(d, set_addr_t'(RB_CLK_STATUS + 1), 32'd0);  // unmapped
      end
      end_test("register writes and readback");

      for (int d = 0; d < NDB; d++) begin
         for (int c = 0; c < NCH; c++) begin
            rx_off[d][c] = {rand_iq(), rand_iq()};
            write_reg(d, set_addr_t'(SR_RX_FE_BASE + c * SR_FE_CHAN_OFFSET), rx_off[d][c]);
         end
      end
      run_rx(100);
      end_test("rx dc offset");

      run_tx_frames(1'b0);
      run_tx_frames(1'b1);
      end_test("tx frames");

      for (int p = 0; p < 5; p++) begin
         pps = 1'b1;
         @(negedge radio_clk);
         pps = 1'b0;
         repeat (4) @(negedge radio_clk);  // synchronizer and edge detect
         repeat ($urandom_range(10, 40)) @(negedge radio_clk);
         for (int d = 0; d < NDB; d++) begin
            read_check(d, RB_CLK_STATUS, status_word(clock_status, 1'b1));  // held until next pulse
         end
      end
      repeat (PPS_TIMEOUT + 8) @(negedge radio_clk);
      for (int d = 0; d < NDB; d++) read_check(d, RB_CLK_STATUS, status_word(clock_status, 1'b0));
      end_test("pps presence");

      for (int i = 0; i < 20; i++) write_reg($urandom % NDB, unmapped_addr(), $urandom);
      @(negedge radio_clk);
      check_regs();
      run_rx(4);               // offsets untouched too
      for (int i = 0; i < 12; i++) begin
         write_db($urandom % NDB, $urandom % 6, $urandom);
         @(negedge radio_clk);
         check_regs();          // other slice keeps its values
      end
      end_test("settings isolation");

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(2 * HALF_PERIOD * (TEST_CYCLES + MARGIN));
      $display("Error: run did not finish within %0d cycles", TEST_CYCLES + MARGIN);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

/* files.f */
hdl/radio_core_pkg.sv
hdl/pps_detect.sv
hdl/symbol_modulator.sv
hdl/db_control.sv
hdl/fe_control.sv
hdl/radio_core.sv
test/radio_core_tb.sv

/* Bender.yml */
package:
  name: radio_core

sources:
  # package first, then leaf modules, then the top level
  - hdl/radio_core_pkg.sv
  - hdl/pps_detect.sv
  - hdl/symbol_modulator.sv
  - hdl/db_control.sv
  - hdl/fe_control.sv
  - hdl/radio_core.sv

  - target: test
    files:
      - test/radio_core_tb.sv
